/* common/download_pkg.sv */
// Download bus definitions
// Widths of the download bus, the kinds of download it carries and
// the registered word that the decoder hands to the execute units.

`default_nettype none

package download_pkg;

	// ======================================================================
	// Bus widths
	// ======================================================================

	localparam int DL_ADDR_BITS  = 25;
	localparam int DL_DATA_BITS  = 16;
	localparam int DL_INDEX_BITS = 8;

	// Copier header in front of the ROM image, in bytes
	localparam int CART_HEADER_SKIP = 512;

	// ======================================================================
	// Download kinds
	// ======================================================================

	// Index low six bits zero is a cartridge, all index bits set a cheat file
	typedef enum logic [1:0] {
		DL_NONE  = 2'd0,
		DL_CART  = 2'd1,
		DL_CHEAT = 2'd2
	} dl_kind_t;

	// One registered bus word, 44 bits
	typedef struct packed {
		dl_kind_t                 kind;
		logic                     wr;
		logic [DL_ADDR_BITS-1:0]  addr;
		logic [DL_DATA_BITS-1:0]  data;
	} dl_word_t;

endpackage

`default_nettype wire

/* common/cart_pkg.sv */
// Cartridge description definitions
// Header modes, ROM type codes, header byte offsets, address masks,
// work RAM fill patterns and the cheat record layout.

`default_nettype none

package cart_pkg;

	import download_pkg::*;

	// ======================================================================
	// ROM header
	// ======================================================================

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_t;

	// Raw ROM type as the core expects it
	typedef logic [7:0] rom_type_t;

	localparam rom_type_t ROM_LO   = 8'd0;
	localparam rom_type_t ROM_HI   = 8'd1;
	localparam rom_type_t ROM_EXHI = 8'd2;

	// Size byte sits at the offset, RAM byte two bytes later
	localparam logic [DL_ADDR_BITS-1:0] HDR_OFFSET_LO   = DL_ADDR_BITS'(24'h007FD6 + CART_HEADER_SKIP);
	localparam logic [DL_ADDR_BITS-1:0] HDR_OFFSET_HI   = DL_ADDR_BITS'(24'h00FFD6 + CART_HEADER_SKIP);
	localparam logic [DL_ADDR_BITS-1:0] HDR_OFFSET_EXHI = DL_ADDR_BITS'(24'h40FFD6 + CART_HEADER_SKIP);

	localparam int MASK_BITS = 24;
	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;

	typedef struct packed {
		rom_type_t              rom_type;
		logic [MASK_BITS-1:0]   rom_mask;
		logic [MASK_BITS-1:0]   ram_mask;
	} cart_info_t;

	// ======================================================================
	// Work RAM fill and cheats
	// ======================================================================

	typedef enum logic [1:0] {
		FILL_9966 = 2'd0,
		FILL_00FF = 2'd1,
		FILL_55   = 2'd2,
		FILL_FF   = 2'd3
	} wram_init_t;

	localparam int FILL_ADDR_BITS = 17;

	// Values are big endian, arranged by the code generator
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

/* verilog/download_decode.sv */
// Download bus decoder
// Registers the download bus, sorts each word by download kind and
// flags the first cycle of a cartridge download.

`default_nettype none

module download_decode import download_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  logic [DL_INDEX_BITS-1:0]  ioctl_index,
	input  logic [DL_ADDR_BITS-1:0]   ioctl_addr,
	input  logic [DL_DATA_BITS-1:0]   ioctl_dout,
	output dl_word_t                  dl,
	output logic                      cart_start,
	output logic                      cart_active
);

	dl_kind_t                 next_kind;
	dl_kind_t                 kind_q;
	logic                     wr_q;
	logic [DL_ADDR_BITS-1:0]  addr_q;
	logic [DL_DATA_BITS-1:0]  data_q;

	// Cheat index 0xFF never matches the cartridge rule
	always_comb begin
		next_kind = DL_NONE;
		if (ioctl_download) begin
			if (ioctl_index[5:0] == 6'd0)
				next_kind = DL_CART;
			else if (&ioctl_index)
				next_kind = DL_CHEAT;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kind_q     <= DL_NONE;
			wr_q       <= 1'b0;
			cart_start <= 1'b0;
		end else begin
			kind_q     <= next_kind;
			wr_q       <= ioctl_download & ioctl_wr;
			// kind_q still holds the previous kind here
			cart_start <= (next_kind == DL_CART) && (kind_q != DL_CART);
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= ioctl_addr;
		data_q <= ioctl_dout;
	end

	assign dl          = '{kind: kind_q, wr: wr_q, addr: addr_q, data: data_q};
	assign cart_active = (kind_q == DL_CART);

	// A cartridge download starts once, never on back to back cycles
	a_start_single: assert property (@(posedge clk_sys) disable iff (reset)
		cart_start |=> !cart_start);

endmodule

`default_nettype wire

/* cart_detect/header_detect.sv */
// Cartridge header detection
// Picks ROM type, ROM and RAM size codes and the region out of the
// cartridge download, turns the size codes into address masks and
// selects the video standard once the download is over.

`default_nettype none

module header_detect import download_pkg::*, cart_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  dl_word_t      dl,
	input  logic          cart_active,
	input  header_mode_t  header_mode,
	input  logic [1:0]    video_region,
	output cart_info_t    cart_info,
	output logic          pal
);

	localparam logic [MASK_BITS-1:0] MASK_BASE = MASK_BITS'(1024);

	logic                     cart_wr;
	logic                     hdr_forced;
	logic [DL_ADDR_BITS-1:0]  size_offset;
	logic [DL_ADDR_BITS-1:0]  ram_offset;

	logic [3:0]               rom_size;
	logic [3:0]               ram_size;
	logic                     rom_region;
	logic                     size_upd;
	rom_type_t                rom_type;
	logic [MASK_BITS-1:0]     rom_mask;
	logic [MASK_BITS-1:0]     ram_mask;

	assign cart_wr = (dl.kind == DL_CART) && dl.wr;

	// Header location for the forced modes
	always_comb begin
		hdr_forced  = 1'b1;
		size_offset = HDR_OFFSET_LO;
		case (header_mode)
			HDR_LOROM:   size_offset = HDR_OFFSET_LO;
			HDR_HIROM:   size_offset = HDR_OFFSET_HI;
			HDR_EXHIROM: size_offset = HDR_OFFSET_EXHI;
			default:     hdr_forced  = 1'b0;
		endcase
		ram_offset = size_offset + DL_ADDR_BITS'(2);
	end

	// ======================================================================
	// Header fields
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_region <= 1'b0;
			rom_type   <= ROM_LO;
			size_upd   <= 1'b0;
		end else begin
			size_upd <= cart_wr;
			if (cart_wr) begin
				if (dl.addr == '0) begin
					rom_size <= DEFAULT_ROM_SIZE;
					ram_size <= 4'd0;
					// Auto mode takes both size codes from the low byte
					if (header_mode == HDR_AUTO && dl.data[7:0] != 8'd0)
						{ram_size, rom_size} <= dl.data[7:0];
					case (header_mode)
						HDR_NONE,
						HDR_LOROM:   rom_type <= ROM_LO;
						HDR_HIROM:   rom_type <= ROM_HI;
						HDR_EXHIROM: rom_type <= ROM_EXHI;
						default:     rom_type <= dl.data[15:8];
					endcase
				end
				if (dl.addr == DL_ADDR_BITS'(2))
					rom_region <= dl.data[8];
				if (hdr_forced && dl.addr == size_offset)
					rom_size <= dl.data[11:8];
				if (hdr_forced && dl.addr == ram_offset)
					ram_size <= dl.data[3:0];
			end
		end
	end

	// ======================================================================
	// Masks and video standard
	// ======================================================================

	// Masks follow the size codes one cycle later
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_mask <= '0;
			ram_mask <= '0;
			pal      <= 1'b0;
		end else begin
			if (size_upd) begin
				rom_mask <= (MASK_BASE << rom_size) - MASK_BITS'(1);
				ram_mask <= (ram_size != 4'd0) ?
					(MASK_BASE << ram_size) - MASK_BITS'(1) : '0;
			end
			// Region 0 means auto, otherwise bit 0 picks PAL
			if (!cart_active)
				pal <= (video_region == 2'd0) ? rom_region : video_region[0];
		end
	end

	assign cart_info = '{rom_type: rom_type, rom_mask: rom_mask, ram_mask: ram_mask};

endmodule

`default_nettype wire

/* verilog/cheat_loader.sv */
// Cheat code loader
// Collects the eight 16-bit words of one cheat record from a cheat
// download and strobes the finished record out.

`default_nettype none

module cheat_loader import download_pkg::*, cart_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  dl_word_t     dl,
	output cheat_code_t  cheat_code,
	output logic         cheat_valid
);

	logic cheat_wr;

	assign cheat_wr = (dl.kind == DL_CHEAT) && dl.wr;

	// Last word of the record, replace high half
	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= cheat_wr && (dl.addr[3:0] == 4'd14);
	end

	// Word position comes from the low address nibble
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (dl.addr[3:0])
				4'd0:    cheat_code.flags[15:0]    <= dl.data;
				4'd2:    cheat_code.flags[31:16]   <= dl.data;
				4'd4:    cheat_code.address[15:0]  <= dl.data;
				4'd6:    cheat_code.address[31:16] <= dl.data;
				4'd8:    cheat_code.compare[15:0]  <= dl.data;
				4'd10:   cheat_code.compare[31:16] <= dl.data;
				4'd12:   cheat_code.replace[15:0]  <= dl.data;
				4'd14:   cheat_code.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	// One record strobe per eight-word record
	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |=> !cheat_valid);

endmodule

`default_nettype wire

/* verilog/ram_clear.sv */
// Work RAM clear
// Sweeps every work RAM address once after a cartridge download
// starts and writes the selected power-on fill pattern.

`default_nettype none

module ram_clear import cart_pkg::*; (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       cart_start,
	input  wram_init_t                 wram_init,
	output logic                       fill_wr,
	output logic [FILL_ADDR_BITS-1:0]  fill_addr,
	output logic [7:0]                 fill_data
);

	logic                       next_wr;
	logic [FILL_ADDR_BITS-1:0]  next_addr;

	function automatic logic [7:0] fill_pattern(input wram_init_t mode,
			input logic [FILL_ADDR_BITS-1:0] addr);
		logic [7:0] value;
		case (mode)
			FILL_9966: value = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			FILL_00FF: value = (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			FILL_55:   value = 8'h55;
			default:   value = 8'hFF;
		endcase
		return value;
	endfunction

	// A new start restarts the sweep at address 0
	always_comb begin
		next_wr   = fill_wr;
		next_addr = fill_addr;
		if (cart_start) begin
			next_wr   = 1'b1;
			next_addr = '0;
		end else if (fill_wr) begin
			if (&fill_addr) begin
				next_wr   = 1'b0;
				next_addr = '0;
			end else begin
				next_addr = fill_addr + FILL_ADDR_BITS'(1);
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fill_wr   <= 1'b0;
			fill_addr <= '0;
		end else begin
			fill_wr   <= next_wr;
			fill_addr <= next_addr;
		end
	end

	// Data registered together with its address
	always_ff @(posedge clk_sys)
		fill_data <= fill_pattern(wram_init, next_addr);

	a_idle_addr: assert property (@(posedge clk_sys) disable iff (reset)
		!fill_wr |-> (fill_addr == '0));

endmodule

`default_nettype wire

/* verilog/cart_loader_top.sv */
// Cartridge loading front end
// Decodes the download bus and feeds header detection, cheat
// assembly and the work RAM clear, which run side by side.

`default_nettype none

module cart_loader_top import download_pkg::*, cart_pkg::*; (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       ioctl_download,
	input  logic [DL_INDEX_BITS-1:0]   ioctl_index,
	input  logic [DL_ADDR_BITS-1:0]    ioctl_addr,
	input  logic [DL_DATA_BITS-1:0]    ioctl_dout,
	input  logic                       ioctl_wr,
	input  header_mode_t               header_mode,
	input  logic [1:0]                 video_region,
	input  wram_init_t                 wram_init,
	output cart_info_t                 cart_info,
	output logic                       pal,
	output cheat_code_t                cheat_code,
	output logic                       cheat_valid,
	output logic                       fill_wr,
	output logic [FILL_ADDR_BITS-1:0]  fill_addr,
	output logic [7:0]                 fill_data
);

	dl_word_t  dl;
	logic      cart_start;
	logic      cart_active;

	// ======================================================================
	// Decode
	// ======================================================================

	download_decode u_decode (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.dl             (dl),
		.cart_start     (cart_start),
		.cart_active    (cart_active)
	);

	// ======================================================================
	// Execute units
	// ======================================================================

	header_detect u_header (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.cart_active  (cart_active),
		.header_mode  (header_mode),
		.video_region (video_region),
		.cart_info    (cart_info),
		.pal          (pal)
	);

	cheat_loader u_cheat (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	ram_clear u_clear (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cart_start (cart_start),
		.wram_init  (wram_init),
		.fill_wr    (fill_wr),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data)
	);

endmodule

`default_nettype wire

/* testbench/cart_loader_tb.sv */
// Cartridge loader testbench
// Directed tests over the download bus for header detection, cheat
// record assembly and the work RAM sweep with each fill pattern.

`default_nettype none

module cart_loader_tb import download_pkg::*, cart_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SWEEP_CYCLES   = 1 << FILL_ADDR_BITS;
	localparam int TIMEOUT_CYCLES = 4 * SWEEP_CYCLES + 2000;

	logic                       clk_sys = 1'b0;
	logic                       reset = 1'b1;
	logic                       ioctl_download = 1'b0;
	logic [DL_INDEX_BITS-1:0]   ioctl_index = '0;
	logic [DL_ADDR_BITS-1:0]    ioctl_addr = '0;
	logic [DL_DATA_BITS-1:0]    ioctl_dout = '0;
	logic                       ioctl_wr = 1'b0;
	header_mode_t               header_mode = HDR_AUTO;
	logic [1:0]                 video_region = 2'd0;
	wram_init_t                 wram_init = FILL_9966;

	cart_info_t                 cart_info;
	logic                       pal;
	cheat_code_t                cheat_code;
	logic                       cheat_valid;
	logic                       fill_wr;
	logic [FILL_ADDR_BITS-1:0]  fill_addr;
	logic [7:0]                 fill_data;

	logic [31:0]                rng_state = 32'h83e4870b;
	int                         cycle_count = 0;
	int                         valid_count = 0;

	cart_loader_top DUT (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.header_mode    (header_mode),
		.video_region   (video_region),
		.wram_init      (wram_init),
		.cart_info      (cart_info),
		.pal            (pal),
		.cheat_code     (cheat_code),
		.cheat_valid    (cheat_valid),
		.fill_wr        (fill_wr),
		.fill_addr      (fill_addr),
		.fill_data      (fill_data)
	);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES)
			fail_run("Timeout, the tests did not finish within the cycle limit");
	end

	// Record strobes seen on the bus side of the DUT
	always @(posedge clk_sys) begin
		if (!reset && cheat_valid)
			valid_count = valid_count + 1;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	task automatic fail_run(input string line);
		$display(">>> FAIL");
		$display("%s", line);
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] got);
		assert (got === expected)
		else fail_run($sformatf("Fail %s: expected %0h got %0h", name, expected, got));
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond)
		else fail_run(what);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_word(output logic [15:0] word);
		rng_state = xorshift32(rng_state);
		word = rng_state[15:0];
	endtask

	// 1 KiB shifted by the size code, less one
	function automatic logic [MASK_BITS-1:0] size_to_mask(input logic [3:0] code,
			input logic zero_is_none);
		logic [31:0] bytes;
		bytes = 32'd1024 << code;
		if (zero_is_none && code == 4'd0)
			bytes = 32'd1;
		return MASK_BITS'(bytes - 32'd1);
	endfunction

	function automatic logic [7:0] expected_fill(input wram_init_t mode,
			input logic [FILL_ADDR_BITS-1:0] addr);
		logic [7:0] value;
		value = 8'hFF;
		if (mode == FILL_9966)
			value = (addr[8] != addr[2]) ? 8'h66 : 8'h99;
		else if (mode == FILL_00FF)
			value = (addr[9] != addr[0]) ? 8'hFF : 8'h00;
		else if (mode == FILL_55)
			value = 8'h55;
		return value;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	// One bus word, wr high for a single cycle
	task automatic write_word(input logic [7:0] index, input logic [DL_ADDR_BITS-1:0] addr,
			input logic [15:0] data);
		ioctl_download = 1'b1;
		ioctl_index    = index;
		ioctl_addr     = addr;
		ioctl_dout     = data;
		ioctl_wr       = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		wait_cycles(2);
	endtask

	task automatic check_cart(input logic [7:0] rom_type, input logic [3:0] rom_code,
			input logic [3:0] ram_code);
		check_value("rom_type", 128'(rom_type), 128'(cart_info.rom_type));
		check_value("rom_mask", 128'(size_to_mask(rom_code, 1'b0)), 128'(cart_info.rom_mask));
		check_value("ram_mask", 128'(size_to_mask(ram_code, 1'b1)), 128'(cart_info.ram_mask));
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic test_reset_values();
		check_value("cheat_valid", 128'(0), 128'(cheat_valid));
		check_value("fill_wr", 128'(0), 128'(fill_wr));
		check_value("fill_addr", 128'(0), 128'(fill_addr));
		check_value("rom_mask", 128'(0), 128'(cart_info.rom_mask));
		check_value("ram_mask", 128'(0), 128'(cart_info.ram_mask));
		check_value("pal", 128'(0), 128'(pal));
	endtask

	task automatic test_auto_header();
		logic [15:0] word0;
		logic [15:0] rnd;
		int          a;
		word0        = 16'h0229;
		header_mode  = HDR_AUTO;
		video_region = 2'd0;
		write_word(8'h00, '0, word0);
		// Fields land a cycle before the masks, still at reset here
		wait_cycles(1);
		check_value("rom_type", 128'(word0[15:8]), 128'(cart_info.rom_type));
		check_value("rom_mask", 128'(0), 128'(cart_info.rom_mask));
		wait_cycles(1);
		check_cart(word0[15:8], word0[3:0], word0[7:4]);
		draw_word(rnd);
		write_word(8'h00, 25'd2, {rnd[15:9], 1'b1, rnd[7:0]});
		for (a = 4; a < 64; a = a + 2) begin
			draw_word(rnd);
			write_word(8'h00, 25'(a), rnd);
		end
		wait_cycles(2);
		check_cart(word0[15:8], word0[3:0], word0[7:4]);
		// Region bit is stored but pal holds while the download runs
		check_value("pal", 128'(0), 128'(pal));
		end_download();
		check_value("pal", 128'(1), 128'(pal));
	endtask

	task automatic test_forced_hirom();
		logic [15:0] rnd;
		int          a;
		header_mode = HDR_HIROM;
		draw_word(rnd);
		write_word(8'h00, '0, rnd);
		draw_word(rnd);
		write_word(8'h00, 25'd2, {rnd[15:9], 1'b1, rnd[7:0]});
		for (a = 4; a < 64; a = a + 2) begin
			draw_word(rnd);
			write_word(8'h00, 25'(a), rnd);
		end
		draw_word(rnd);
		write_word(8'h00, HDR_OFFSET_HI, {rnd[15:12], 4'hB, rnd[7:0]});
		draw_word(rnd);
		write_word(8'h00, HDR_OFFSET_HI + 25'd2, {rnd[15:4], 4'h3});
		wait_cycles(2);
		check_cart(8'h01, 4'hB, 4'h3);
		// A zero RAM code clears the RAM mask
		draw_word(rnd);
		write_word(8'h00, HDR_OFFSET_HI + 25'd2, {rnd[15:4], 4'h0});
		wait_cycles(2);
		check_cart(8'h01, 4'hB, 4'h0);
		video_region = 2'd2;
		end_download();
		check_value("pal", 128'(0), 128'(pal));
		// Auto region brings back the stored region bit
		video_region = 2'd0;
		wait_cycles(1);
		check_value("pal", 128'(1), 128'(pal));
	endtask

	task automatic test_cheat_record();
		logic [15:0] words [8];
		logic [15:0] rnd;
		cheat_code_t expected;
		int          base_count;
		int          i;
		for (i = 0; i < 8; i++)
			draw_word(words[i]);
		base_count = valid_count;
		for (i = 0; i < 7; i++)
			write_word(8'hFF, 25'(2 * i), words[i]);
		check_true(valid_count == base_count,
			"cheat_valid pulsed before the record was complete");
		write_word(8'hFF, 25'd14, words[7]);
		// Strobe two cycles after the last write
		check_value("cheat_valid", 128'(0), 128'(cheat_valid));
		wait_cycles(1);
		check_value("cheat_valid", 128'(1), 128'(cheat_valid));
		wait_cycles(1);
		check_value("cheat_valid", 128'(0), 128'(cheat_valid));
		expected = '{flags: {words[1], words[0]}, address: {words[3], words[2]},
			compare: {words[5], words[4]}, replace: {words[7], words[6]}};
		check_value("cheat_code", expected, cheat_code);
		end_download();
		check_true(valid_count == base_count + 1, "cheat_valid did not pulse exactly once");
		// Same addresses on a cartridge index leave the record alone
		for (i = 0; i < 8; i++) begin
			draw_word(rnd);
			write_word(8'h00, 25'(2 * i), rnd);
		end
		end_download();
		check_value("cheat_code", expected, cheat_code);
		check_true(valid_count == base_count + 1, "cheat_valid pulsed on a cartridge download");
	endtask

	task automatic test_ram_sweep(input wram_init_t mode);
		logic [FILL_ADDR_BITS-1:0] addr_exp;
		int                        cycles;
		wram_init      = mode;
		ioctl_index    = 8'h00;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		// One cycle to cart_start, one more to the first fill write
		@(negedge clk_sys);
		check_value("fill_wr", 128'(1), 128'(fill_wr));
		cycles = 0;
		while (fill_wr) begin
			addr_exp = FILL_ADDR_BITS'(cycles);
			check_value("fill_addr", 128'(addr_exp), 128'(fill_addr));
			check_value("fill_data", 128'(expected_fill(mode, addr_exp)), 128'(fill_data));
			cycles = cycles + 1;
			@(negedge clk_sys);
		end
		check_value("fill_wr cycles", 128'(SWEEP_CYCLES), 128'(cycles));
		check_value("fill_addr", 128'(0), 128'(fill_addr));
	endtask

	initial begin
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		wait_cycles(2);
		test_reset_values();
		test_auto_header();
		test_forced_hirom();
		test_cheat_record();
		test_ram_sweep(FILL_9966);
		test_ram_sweep(FILL_00FF);
		test_ram_sweep(FILL_55);
		test_ram_sweep(FILL_FF);
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
common/download_pkg.sv
common/cart_pkg.sv
verilog/download_decode.sv
cart_detect/header_detect.sv
verilog/cheat_loader.sv
verilog/ram_clear.sv
verilog/cart_loader_top.sv
testbench/cart_loader_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' vlog.f)

.PHONY: all run clean

all: run

obj_dir/Vcart_loader_tb: vlog.f $(SRCS)
	verilator --binary --assert -j 0 --timescale 1ns/100ps \
		--top-module cart_loader_tb -f vlog.f

run: obj_dir/Vcart_loader_tb
	./obj_dir/Vcart_loader_tb

clean:
	rm -rf obj_dir
